/* tb.f */
+incdir+rtl
rtl/cov_pkg.sv
rtl/cov_seq.sv
rtl/ikh_builder.sv
rtl/operand_mux.sv
rtl/matmul_engine.sv
rtl/matrix_store.sv
rtl/cov_update_top.sv
verif/cov_checker.sv
verif/cov_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cov_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "tests failed" $(LOG); then echo "check: failures in $(LOG)"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "check: run incomplete"; exit 1; fi
	@echo "check: simulation clean"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/cov_tb.sv */
`timescale 1ns/1ps
`include "cov_cfg.svh"

module cov_tb;
    import cov_pkg::*;

    localparam int     N              = `COV_STATE_DIM;
    localparam int     M              = `COV_MEAS_DIM;
    localparam int     CLK_PERIOD     = 10;
    localparam int     RESET_CYCLES   = 16;
    localparam int     NUM_RUNS       = 26;
    localparam int     CYCLES_PER_RUN = 400;
    localparam longint WATCHDOG_NS    =
        longint'(NUM_RUNS) * CYCLES_PER_RUN * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
    localparam longint ELEM_MAX       = (longint'(1) <<< (`COV_DATA_W - 1)) - 1;
    localparam longint ELEM_MIN       = -ELEM_MAX - 1;
    localparam longint ONE            = longint'(1) <<< `COV_FRAC_W;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start_drv;
    kf_in_t      in_drv;
    mat_t        p_w;
    logic        done_w;
    mat_t        exp_p;
    int          n_tests;
    int          n_fail;
    logic [31:0] lcg_state = 32'hebcb_9cf5;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------
    // random numbers
    // ------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // small values span about -2.0 .. +2.0
    function automatic elem_t rand_elem(input bit full);
        logic [31:0] v;
        v = lcg_next();
        if (full) begin
            return elem_t'(v[31:16]);
        end
        return elem_t'(int'(v[25:16]) - 512);
    endfunction

    function automatic kf_in_t rand_input(input bit full);
        kf_in_t x;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < M; c++) begin
                x.k[r][c] = rand_elem(full);
            end
        end
        for (int r = 0; r < M; r++) begin
            for (int c = 0; c < M; c++) begin
                x.r[r][c] = rand_elem(full);
            end
        end
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                x.p[r][c] = rand_elem(full);
            end
        end
        return x;
    endfunction

    // extreme pattern, pushes every stage into clamping
    function automatic kf_in_t big_input();
        kf_in_t x;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < M; c++) begin
                x.k[r][c] = ((r + c) % 2 == 0) ? elem_t'(16'h7fff) : elem_t'(16'h8000);
            end
            for (int c = 0; c < N; c++) begin
                if (r == c) begin
                    x.p[r][c] = elem_t'(16'h7fff);
                end else begin
                    x.p[r][c] = ((r + c) % 2 == 0) ? elem_t'(16'h6000) : elem_t'(16'h8000);
                end
            end
        end
        for (int r = 0; r < M; r++) begin
            for (int c = 0; c < M; c++) begin
                x.r[r][c] = (r == c) ? elem_t'(16'h7fff) : elem_t'(16'h4000);
            end
        end
        return x;
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic elem_t clamp_elem(input longint v);
        if (v > ELEM_MAX) begin
            return elem_t'(ELEM_MAX);
        end
        if (v < ELEM_MIN) begin
            return elem_t'(ELEM_MIN);
        end
        return elem_t'(v);
    endfunction

    function automatic mat_t mat_mult(input mat_t a, input mat_t b);
        mat_t   c;
        longint acc;
        for (int r = 0; r < N; r++) begin
            for (int col = 0; col < N; col++) begin
                acc = 0;
                for (int k = 0; k < N; k++) begin
                    acc += longint'($signed(a[r][k])) * longint'($signed(b[k][col]));
                end
                // floor rescale, then clamp
                c[r][col] = clamp_elem(acc >>> `COV_FRAC_W);
            end
        end
        return c;
    endfunction

    function automatic mat_t cov_ref(input kf_in_t x);
        mat_t kp;
        mat_t rp;
        mat_t ktp;
        mat_t ikh;
        mat_t ikht;
        mat_t krkt;
        mat_t ikhpikht;
        mat_t res;
        kp  = '0;
        rp  = '0;
        ktp = '0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                if (c < M) begin
                    kp[r][c]  = x.k[r][c];
                    ikh[r][c] = clamp_elem(((r == c) ? ONE : 64'sd0) - longint'(x.k[r][c]));
                end else begin
                    ikh[r][c] = (r == c) ? elem_t'(ONE) : elem_t'(0);
                end
                if (r < M) begin
                    ktp[r][c] = x.k[c][r];
                end
                if (r < M && c < M) begin
                    rp[r][c] = x.r[r][c];
                end
            end
        end
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                ikht[r][c] = ikh[c][r];
            end
        end
        krkt     = mat_mult(mat_mult(kp, rp), ktp);
        ikhpikht = mat_mult(mat_mult(ikh, x.p), ikht);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                res[r][c] = clamp_elem(longint'(krkt[r][c]) + longint'(ikhpikht[r][c]));
            end
        end
        return res;
    endfunction

    assign exp_p = cov_ref(in_drv);

    // ------------------------------
    // DUT and checker
    // ------------------------------
    cov_update_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_i    (in_drv),
        .start_i (start_drv),
        .p_o     (p_w),
        .done_o  (done_w)
    );

    cov_checker chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_drv),
        .in_i      (in_drv),
        .exp_i     (exp_p),
        .done_i    (done_w),
        .p_i       (p_w),
        .n_tests_o (n_tests),
        .n_fail_o  (n_fail)
    );

    // one full start/done handshake, start held for extra cycles after done
    task automatic run_case(input kf_in_t x, input int hold_cycles);
        @(posedge clk);
        #1;
        in_drv    = x;
        start_drv = 1'b1;
        do @(posedge clk); while (done_w !== 1'b1);
        repeat (hold_cycles) @(posedge clk);
        #1;
        start_drv = 1'b0;
        do @(posedge clk); while (done_w !== 1'b0);
    endtask

    initial begin
        kf_in_t x;
        rst_n     = 1'b0;
        start_drv = 1'b0;
        in_drv    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // idle stretch before the first start
        repeat (8) @(posedge clk);
        // K zero, result must be P
        for (int i = 0; i < 2; i++) begin
            x   = rand_input(i == 1);
            x.k = '0;
            run_case(x, 0);
        end
        for (int i = 0; i < 20; i++) begin
            run_case(rand_input(1'b0), 0);
        end
        run_case(big_input(), 0);
        run_case(rand_input(1'b1), 0);
        // long start hold, then an immediate rerun
        run_case(rand_input(1'b0), 50);
        run_case(rand_input(1'b0), 0);
        repeat (4) @(posedge clk);
        #1;
        $display("%0d tests run, %0d passed, %0d failed", n_tests, n_tests - n_fail, n_fail);
        if (n_tests != NUM_RUNS + 1) begin
            $display("checker reported %0d tests instead of %0d", n_tests, NUM_RUNS + 1);
        end
        if (n_fail == 0 && n_tests == NUM_RUNS + 1) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: runs did not complete within %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule

/* verif/cov_checker.sv */
`timescale 1ns/1ps
`include "cov_cfg.svh"

module cov_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_i,
    input  cov_pkg::kf_in_t in_i,
    input  cov_pkg::mat_t   exp_i,
    input  logic            done_i,
    input  cov_pkg::mat_t   p_i,
    output int              n_tests_o,
    output int              n_fail_o
);
    import cov_pkg::*;

    localparam int N = `COV_STATE_DIM;

    logic   start_q;
    logic   done_q;
    logic   busy;
    logic   seen_start;
    logic   fall_due;
    int     run_errs;
    int     idle_errs;
    int     run_no;
    kf_in_t in_hold;
    mat_t   p_hold;

    task automatic close_test(input string name, input int errs);
        n_tests_o = n_tests_o + 1;
        if (errs == 0) begin
            $display("test %0d %s: pass", n_tests_o, name);
        end else begin
            n_fail_o = n_fail_o + 1;
            $display("test %0d %s: FAIL with %0d errors", n_tests_o, name, errs);
        end
    endtask

    task automatic fault(input string what);
        run_errs = run_errs + 1;
        $display("error at %0d ns: %s", $time, what);
    endtask

    task automatic compare_result();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                if (p_i[r][c] !== exp_i[r][c]) begin
                    run_errs = run_errs + 1;
                    $display("FAILED at %0d ns: p_o[%0d][%0d] expected %0d, got %0d",
                             $time, r, c, $signed(exp_i[r][c]), $signed(p_i[r][c]));
                end
            end
        end
    endtask

    // ------------------------------
    // sampled on every rising edge
    // ------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            start_q    = 1'b0;
            done_q     = 1'b0;
            busy       = 1'b0;
            seen_start = 1'b0;
            fall_due   = 1'b0;
            run_errs   = 0;
            idle_errs  = 0;
            run_no     = 0;
            n_tests_o  = 0;
            n_fail_o   = 0;
        end else begin
            // outputs must sit at reset values until the first run
            if (!seen_start && (done_i !== 1'b0 || p_i !== '0)) begin
                if (idle_errs == 0) begin
                    $display("error at %0d ns: done_o or p_o left reset value before start",
                             $time);
                end
                idle_errs = idle_errs + 1;
            end
            if (start_i && !start_q && !busy) begin
                if (!seen_start) begin
                    close_test("reset idle", idle_errs);
                end
                seen_start = 1'b1;
                busy       = 1'b1;
                run_no     = run_no + 1;
                run_errs   = 0;
                in_hold    = in_i;
            end else if (busy && !done_i && in_i !== in_hold) begin
                fault("in_i changed while the run was in progress");
            end
            if (done_i && !done_q) begin
                if (!busy) begin
                    $display("error at %0d ns: done_o rose with no run in progress", $time);
                    close_test("unexpected done", 1);
                end else begin
                    compare_result();
                    p_hold = p_i;
                end
            end
            if (done_i && done_q && p_i !== p_hold) begin
                fault("p_o changed while done_o was high");
            end
            if (fall_due && done_i) begin
                fault("done_o stayed high after start_i fell");
            end
            if (!done_i && done_q && busy) begin
                if (start_q) begin
                    fault("done_o fell while start_i was still high");
                end
                close_test($sformatf("run %0d", run_no), run_errs);
                busy = 1'b0;
            end
            fall_due = done_i && !start_i;
            start_q  = start_i;
            done_q   = done_i;
        end
    end

endmodule

/* rtl/cov_update_top.sv */
`timescale 1ns/1ps

module cov_update_top (
    input  logic            clk,
    input  logic            rst_n,
    input  cov_pkg::kf_in_t in_i,
    input  logic            start_i,
    output cov_pkg::mat_t   p_o,
    output logic            done_o
);
    import cov_pkg::*;

    phase_e  phase;
    logic    mm_go;
    logic    mm_done;
    logic    cap_en;
    mat_t    ikh;
    mat_t    kr;
    mat_t    ikhp;
    mat_t    mm_c;
    mm_ops_t mm_ops;

    cov_seq u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .mm_done_i (mm_done),
        .phase_o   (phase),
        .mm_go_o   (mm_go),
        .cap_en_o  (cap_en),
        .done_o    (done_o)
    );

    ikh_builder u_ikh (
        .k_i   (in_i.k),
        .ikh_o (ikh)
    );

    operand_mux u_mux (
        .phase_i (phase),
        .in_i    (in_i),
        .ikh_i   (ikh),
        .kr_i    (kr),
        .ikhp_i  (ikhp),
        .ops_o   (mm_ops)
    );

    // single multiplier shared by all four products
    matmul_engine u_mm (
        .clk    (clk),
        .rst_n  (rst_n),
        .go_i   (mm_go),
        .ops_i  (mm_ops),
        .c_o    (mm_c),
        .done_o (mm_done)
    );

    matrix_store u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .phase_i  (phase),
        .cap_en_i (cap_en),
        .c_i      (mm_c),
        .kr_o     (kr),
        .ikhp_o   (ikhp),
        .p_o      (p_o)
    );

endmodule

/* rtl/matrix_store.sv */
`timescale 1ns/1ps
`include "cov_cfg.svh"

module matrix_store (
    input  logic            clk,
    input  logic            rst_n,
    input  cov_pkg::phase_e phase_i,
    input  logic            cap_en_i,
    input  cov_pkg::mat_t   c_i,
    output cov_pkg::mat_t   kr_o,
    output cov_pkg::mat_t   ikhp_o,
    output cov_pkg::mat_t   p_o
);
    import cov_pkg::*;

    localparam int N = `COV_STATE_DIM;

    mat_t krkt_q;
    mat_t ikhpikht_q;
    mat_t sum_w;

    // ------------------------------
    // final element-wise sum
    // ------------------------------
    always_comb begin : sum_blk
        elem_t                        ea;
        elem_t                        eb;
        logic signed [`COV_ACC_W-1:0] s;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                ea = krkt_q[r][c];
                eb = ikhpikht_q[r][c];
                s  = ea + eb;
                sum_w[r][c] = sat_elem(s);
            end
        end
    end

    // slot picked by the phase the sequencer reports
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kr_o       <= '0;
            krkt_q     <= '0;
            ikhp_o     <= '0;
            ikhpikht_q <= '0;
            p_o        <= '0;
        end else if (cap_en_i) begin
            case (phase_i)
                PH_KR:       kr_o       <= c_i;
                PH_KRKT:     krkt_q     <= c_i;
                PH_IKHP:     ikhp_o     <= c_i;
                PH_IKHPIKHT: ikhpikht_q <= c_i;
                PH_SUM:      p_o        <= sum_w;
                default: begin
                end
            endcase
        end
    end

endmodule

/* rtl/matmul_engine.sv */
`timescale 1ns/1ps
`include "cov_cfg.svh"

module matmul_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             go_i,
    input  cov_pkg::mm_ops_t ops_i,
    output cov_pkg::mat_t    c_o,
    output logic             done_o
);
    import cov_pkg::*;

    localparam int N  = `COV_STATE_DIM;
    localparam int IW = $clog2(N);
    localparam logic [IW-1:0] LAST = IW'(N - 1);

    logic                            busy_q;
    logic [IW-1:0]                   row_q;
    logic [IW-1:0]                   col_q;
    logic [IW-1:0]                   k_q;
    logic signed [`COV_ACC_W-1:0]    acc_q;
    elem_t                           a_el;
    elem_t                           b_el;
    logic signed [2*`COV_DATA_W-1:0] prod;
    logic signed [`COV_ACC_W-1:0]    sum;

    // one multiply-accumulate per cycle
    always_comb begin
        a_el = ops_i.a[row_q][k_q];
        b_el = ops_i.b[k_q][col_q];
        prod = a_el * b_el;
        sum  = acc_q + prod;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            row_q  <= '0;
            col_q  <= '0;
            k_q    <= '0;
            acc_q  <= '0;
            c_o    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (go_i) begin
                busy_q <= 1'b1;
                row_q  <= '0;
                col_q  <= '0;
                k_q    <= '0;
                acc_q  <= '0;
            end else if (busy_q) begin
                if (k_q == LAST) begin
                    // last inner term, rescale Q16.16 back to Q8.8
                    c_o[row_q][col_q] <= sat_elem(sum >>> `COV_FRAC_W);
                    acc_q <= '0;
                    k_q   <= '0;
                    if (col_q == LAST) begin
                        col_q <= '0;
                        if (row_q == LAST) begin
                            busy_q <= 1'b0;
                            done_o <= 1'b1;
                        end else begin
                            row_q <= row_q + 1'b1;
                        end
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end else begin
                    acc_q <= sum;
                    k_q   <= k_q + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/operand_mux.sv */
`timescale 1ns/1ps
`include "cov_cfg.svh"

module operand_mux (
    input  cov_pkg::phase_e  phase_i,
    input  cov_pkg::kf_in_t  in_i,
    input  cov_pkg::mat_t    ikh_i,
    input  cov_pkg::mat_t    kr_i,
    input  cov_pkg::mat_t    ikhp_i,
    output cov_pkg::mm_ops_t ops_o
);
    import cov_pkg::*;

    localparam int N = `COV_STATE_DIM;
    localparam int M = `COV_MEAS_DIM;

    mat_t k_pad;
    mat_t kt_pad;
    mat_t r_pad;
    mat_t ikh_t;

    // ------------------------------
    // padded and transposed views
    // ------------------------------
    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            if (c < M) begin : g_k
                assign k_pad[r][c] = in_i.k[r][c];
            end else begin : g_kz
                assign k_pad[r][c] = '0;
            end
            // K transposed lands in the top rows only
            if (r < M) begin : g_kt
                assign kt_pad[r][c] = in_i.k[c][r];
            end else begin : g_ktz
                assign kt_pad[r][c] = '0;
            end
            if (r < M && c < M) begin : g_r
                assign r_pad[r][c] = in_i.r[r][c];
            end else begin : g_rz
                assign r_pad[r][c] = '0;
            end
            assign ikh_t[r][c] = ikh_i[c][r];
        end
    end

    always_comb begin
        ops_o = '0;
        case (phase_i)
            PH_KR: begin
                ops_o.a = k_pad;
                ops_o.b = r_pad;
            end
            PH_KRKT: begin
                ops_o.a = kr_i;
                ops_o.b = kt_pad;
            end
            PH_IKHP: begin
                ops_o.a = ikh_i;
                ops_o.b = in_i.p;
            end
            PH_IKHPIKHT: begin
                ops_o.a = ikhp_i;
                ops_o.b = ikh_t;
            end
            default: begin
                ops_o = '0;
            end
        endcase
    end

endmodule

/* rtl/ikh_builder.sv */
`timescale 1ns/1ps
`include "cov_cfg.svh"

module ikh_builder (
    input  cov_pkg::kmat_t k_i,
    output cov_pkg::mat_t  ikh_o
);
    import cov_pkg::*;

    localparam int N = `COV_STATE_DIM;
    localparam int M = `COV_MEAS_DIM;
    localparam logic signed [`COV_ACC_W-1:0] ONE_W = 1 <<< `COV_FRAC_W;

    // K*H is K followed by zero columns
    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            localparam logic signed [`COV_ACC_W-1:0] BASE = (r == c) ? ONE_W : '0;
            if (c < M) begin : g_k
                // 1 - K on the diagonal, -K elsewhere
                assign ikh_o[r][c] = sat_elem(BASE - k_i[r][c]);
            end else begin : g_id
                assign ikh_o[r][c] = sat_elem(BASE);
            end
        end
    end

endmodule

/* rtl/cov_seq.sv */
`timescale 1ns/1ps

module cov_seq (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_i,
    input  logic            mm_done_i,
    output cov_pkg::phase_e phase_o,
    output logic            mm_go_o,
    output logic            cap_en_o,
    output logic            done_o
);
    import cov_pkg::*;

    logic start_q;
    logic start_edge;
    logic prod_phase;

    assign start_edge = start_i & ~start_q;
    assign prod_phase = phase_o inside {PH_KR, PH_KRKT, PH_IKHP, PH_IKHPIKHT};

    // store takes the engine result as the product ends, p_o in PH_SUM
    assign cap_en_o = (prod_phase & mm_done_i) | (phase_o == PH_SUM);

    // ------------------------------
    // phase FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
            phase_o <= PH_IDLE;
            mm_go_o <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            start_q <= start_i;
            mm_go_o <= 1'b0;
            case (phase_o)
                PH_IDLE: begin
                    // start edges outside idle are ignored
                    if (start_edge) begin
                        phase_o <= PH_KR;
                        mm_go_o <= 1'b1;
                    end
                end
                PH_KR: begin
                    if (mm_done_i) begin
                        phase_o <= PH_KRKT;
                        mm_go_o <= 1'b1;
                    end
                end
                PH_KRKT: begin
                    if (mm_done_i) begin
                        phase_o <= PH_IKHP;
                        mm_go_o <= 1'b1;
                    end
                end
                PH_IKHP: begin
                    if (mm_done_i) begin
                        phase_o <= PH_IKHPIKHT;
                        mm_go_o <= 1'b1;
                    end
                end
                PH_IKHPIKHT: begin
                    if (mm_done_i) begin
                        phase_o <= PH_SUM;
                    end
                end
                PH_SUM: begin
                    phase_o <= PH_DONE;
                end
                PH_DONE: begin
                    // done stays up at least one cycle, then follows start_i
                    done_o <= 1'b1;
                    if (done_o && !start_i) begin
                        done_o  <= 1'b0;
                        phase_o <= PH_IDLE;
                    end
                end
                default: begin
                    phase_o <= PH_IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/cov_pkg.sv */
`include "cov_cfg.svh"

package cov_pkg;

    typedef logic signed [`COV_DATA_W-1:0] elem_t;

    // row-major, index [row][col]
    typedef elem_t [`COV_STATE_DIM-1:0][`COV_STATE_DIM-1:0] mat_t;
    typedef elem_t [`COV_STATE_DIM-1:0][`COV_MEAS_DIM-1:0]  kmat_t;
    typedef elem_t [`COV_MEAS_DIM-1:0][`COV_MEAS_DIM-1:0]   rmat_t;

    typedef struct packed {
        kmat_t k;
        rmat_t r;
        mat_t  p;
    } kf_in_t;

    typedef struct packed {
        mat_t a;
        mat_t b;
    } mm_ops_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_KR,
        PH_KRKT,
        PH_IKHP,
        PH_IKHPIKHT,
        PH_SUM,
        PH_DONE
    } phase_e;

    // clamp a wide signed value into the element range
    function automatic elem_t sat_elem(input logic signed [`COV_ACC_W-1:0] x);
        logic signed [`COV_ACC_W-1:0] hi;
        logic signed [`COV_ACC_W-1:0] lo;
        hi = {{(`COV_ACC_W-`COV_DATA_W+1){1'b0}}, {(`COV_DATA_W-1){1'b1}}};
        lo = {{(`COV_ACC_W-`COV_DATA_W+1){1'b1}}, {(`COV_DATA_W-1){1'b0}}};
        if (x > hi) begin
            return hi[`COV_DATA_W-1:0];
        end else if (x < lo) begin
            return lo[`COV_DATA_W-1:0];
        end
        return x[`COV_DATA_W-1:0];
    endfunction

endpackage

/* rtl/cov_cfg.svh */
`ifndef COV_CFG_SVH
`define COV_CFG_SVH

// matrix dimensions
`define COV_STATE_DIM 4
// H picks states 0 .. COV_MEAS_DIM-1
`define COV_MEAS_DIM  2

// fixed point element format, Q8.8
`define COV_DATA_W    16
`define COV_FRAC_W    8

// accumulator, holds a full sum of N products
`define COV_ACC_W     40

`endif
